//--- list.f
+incdir+hdl
hdl/game_link_pkg.sv
hdl/uart_rx.sv
hdl/rx_fifo.sv
hdl/uart_decoder.sv
hdl/game_link_rx.sv
sim/game_link_rx_tb.sv

//--- Bender.yml
package:
  name: game_link_rx

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/game_link_pkg.sv
      - hdl/uart_rx.sv
      - hdl/rx_fifo.sv
      - hdl/uart_decoder.sv
      - hdl/game_link_rx.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/game_link_rx_tb.sv

//--- sim/game_link_rx_tb.sv
// Testbench for the game link receive path.
// Sends 8N1 bytes on rx, keeps a reference model of the decoded game state
// and compares the flags, card slots and framing errors after each byte.

`timescale 1ns/1ps
`include "game_link_defines.svh"

module game_link_rx_tb;

    typedef struct packed {
        logic                                        deal;
        logic                                        dealer_finished;
        game_link_pkg::card_value_t [`NUM_CARDS-1:0] cards;
    } model_t;

    localparam int num_bytes      = 61; // 9 + 4 + 6 + 2 + 40.
    localparam int timeout_cycles = num_bytes * 10 * `CLKS_PER_BIT * 12 / 10;

    logic                                        clk;
    logic                                        rst;
    logic                                        rx;
    logic                                        deal;
    logic                                        dealer_finished;
    game_link_pkg::card_value_t [`NUM_CARDS-1:0] card_values;
    logic                                        frame_error;

    model_t      model;
    model_t      exp_q [$];
    string       name_q [$];
    int          due_q [$];
    int          fe_q [$];
    int          cycle_cnt;
    int          fe_count;
    int          fe_expected;
    int          errors;
    int          checks;
    integer      seed;
    logic [31:0] rnd;

    game_link_rx u_game_link_rx (
        .clk             (clk),
        .rst             (rst),
        .rx              (rx),
        .deal            (deal),
        .dealer_finished (dealer_finished),
        .card_values     (card_values),
        .frame_error     (frame_error)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // expected game state after one good byte.
    function automatic model_t decode_ref(model_t cur, logic [7:0] b);
        model_t nxt;
        int     slot;
        nxt = cur;
        if (b[3:0] == 4'd0) begin
            nxt.dealer_finished = b[4];
            nxt.deal            = b[5];
        end else begin
            slot = (b[3:0] <= `NUM_CARDS) ? int'(b[3:0]) - 1 : 0;
            nxt.cards[slot] = b[7:4];
        end
        return nxt;
    endfunction

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_card(input string name, input int slot,
                              input game_link_pkg::card_value_t exp,
                              input game_link_pkg::card_value_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s slot %0d: expected %h, actual %h", name, slot, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAIL %s frame errors: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_state(input string name, input model_t exp, input int fe_exp);
        check_flag({name, " deal"}, exp.deal, deal);
        check_flag({name, " dealer_finished"}, exp.dealer_finished, dealer_finished);
        for (int i = 0; i < `NUM_CARDS; i++) begin
            check_card(name, i, exp.cards[i], card_values[i]);
        end
        check_count(name, fe_exp, fe_count);
    endtask

    // queue the expected state for a check 4 cycles from now.
    task automatic expect_state(input string name);
        exp_q.push_back(model);
        name_q.push_back(name);
        due_q.push_back(cycle_cnt + 4);
        fe_q.push_back(fe_expected);
    endtask

    // one 8N1 frame sent lsb first, starting just after a rising edge.
    task automatic send_byte(input logic [7:0] b, input logic good_stop, input string name);
        rx <= 1'b0;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            rx <= b[i];
            repeat (`CLKS_PER_BIT) @(posedge clk);
        end
        rx <= good_stop;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        if (good_stop) model = decode_ref(model, b);
        else fe_expected++;
        expect_state(name);
        if (!good_stop) begin
            rx <= 1'b1; // one idle bit so the next start edge is clean.
            repeat (`CLKS_PER_BIT) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst) fe_count <= 0;
        else if (frame_error) fe_count <= fe_count + 1;
    end

    always @(posedge clk) begin
        if (exp_q.size() != 0 && cycle_cnt >= due_q[0]) begin
            compare_state(name_q[0], exp_q[0], fe_q[0]);
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            void'(due_q.pop_front());
            void'(fe_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        rx          = 1'b1;
        cycle_cnt   = 0;
        fe_expected = 0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h6429;
        model       = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        expect_state("reset");

        for (int code = 1; code <= `NUM_CARDS; code++) begin
            send_byte({4'(code + 5), 4'(code)}, 1'b1, $sformatf("card slot code %0d", code));
        end

        send_byte(8'h10, 1'b1, "control dealer_finished");
        send_byte(8'h30, 1'b1, "control both flags");
        send_byte(8'h20, 1'b1, "control deal only");
        send_byte(8'h00, 1'b1, "control clear");

        for (int code = 10; code <= 15; code++) begin
            send_byte({4'(code - 9), 4'(code)}, 1'b1, $sformatf("slot 0 alias code %0d", code));
        end

        send_byte(8'ha3, 1'b0, "bad stop bit");
        send_byte(8'h52, 1'b1, "after bad stop");

        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            send_byte(rnd[7:0], 1'b1, $sformatf("random byte %0d", n));
        end

        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- hdl/game_link_rx.sv
// Game link receive top.
// Serial line into the UART receiver, through the byte FIFO, into the
// message decoder that holds the flags and card slots.

`timescale 1ns/1ps
`include "game_link_defines.svh"

module game_link_rx (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         rx,
    output logic                                         deal,
    output logic                                         dealer_finished,
    output game_link_pkg::card_value_t [`NUM_CARDS-1:0] card_values,
    output logic                                         frame_error
);

    game_link_pkg::link_byte_t rx_data;
    game_link_pkg::link_byte_t read_data;
    logic                      rx_done;
    logic                      rx_empty;
    logic                      rd_uart;

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .frame_error (frame_error)
    );

    rx_fifo u_rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (rx_done),
        .wr_data   (rx_data),
        .rd        (rd_uart),
        .read_data (read_data),
        .rx_empty  (rx_empty)
    );

    uart_decoder u_uart_decoder (
        .clk             (clk),
        .rst             (rst),
        .read_data       (read_data),
        .rx_empty        (rx_empty),
        .rd_uart         (rd_uart),
        .deal            (deal),
        .dealer_finished (dealer_finished),
        .card_values     (card_values)
    );

endmodule

//--- hdl/uart_decoder.sv
// Link message decoder.
// Pops bytes from the receive FIFO and keeps the game state: the deal and
// dealer_finished flags from control messages and the card slots from
// card messages.

`timescale 1ns/1ps
`include "game_link_defines.svh"

module uart_decoder (
    input  logic                                         clk,
    input  logic                                         rst,
    input  game_link_pkg::link_byte_t                    read_data,
    input  logic                                         rx_empty,
    output logic                                         rd_uart,
    output logic                                         deal,
    output logic                                         dealer_finished,
    output game_link_pkg::card_value_t [`NUM_CARDS-1:0] card_values
);

    logic                                         decode_en;
    logic                                         rd_uart_nxt;
    logic                                         deal_nxt;
    logic                                         dealer_finished_nxt;
    game_link_pkg::card_value_t [`NUM_CARDS-1:0] card_values_nxt;
    logic [3:0]                                   slot_idx;

    // a pending pop blocks decode, so each byte is seen once.
    assign decode_en = !rx_empty && !rd_uart;

    // codes past the last slot fall back to slot 0.
    always_comb begin
        slot_idx = 4'd0;
        if (read_data.card.slot != 4'd0 && read_data.card.slot <= 4'(`NUM_CARDS)) begin
            slot_idx = read_data.card.slot - 4'd1;
        end
    end

    always_comb begin
        deal_nxt            = deal;
        dealer_finished_nxt = dealer_finished;
        card_values_nxt     = card_values;
        rd_uart_nxt         = 1'b0;
        if (decode_en) begin
            rd_uart_nxt = 1'b1;
            if (read_data.ctrl.opcode == 4'd0) begin
                deal_nxt            = read_data.ctrl.deal;
                dealer_finished_nxt = read_data.ctrl.dealer_finished;
            end else begin
                card_values_nxt[slot_idx] = read_data.card.value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_uart         <= 1'b0;
            deal            <= 1'b0;
            dealer_finished <= 1'b0;
            card_values     <= '0;
        end else begin
            rd_uart         <= rd_uart_nxt;
            deal            <= deal_nxt;
            dealer_finished <= dealer_finished_nxt;
            card_values     <= card_values_nxt;
        end
    end

endmodule

//--- hdl/rx_fifo.sv
// Receive byte FIFO.
// Circular buffer with show-ahead output between the UART receiver and
// the decoder. Writes while full are dropped.

`timescale 1ns/1ps
`include "game_link_defines.svh"

module rx_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr,
    input  game_link_pkg::link_byte_t wr_data,
    input  logic                      rd,
    output game_link_pkg::link_byte_t read_data,
    output logic                      rx_empty
);

    localparam int depth = 2 ** `FIFO_AW;

    game_link_pkg::link_byte_t mem [depth];

    logic [`FIFO_AW-1:0] wr_ptr;
    logic [`FIFO_AW-1:0] rd_ptr;
    logic [`FIFO_AW:0]   count;
    logic                full;
    logic                do_wr;

    assign full      = (count == (`FIFO_AW + 1)'(depth));
    assign rx_empty  = (count == '0);
    assign do_wr     = wr && !full;
    assign read_data = mem[rd_ptr]; // show-ahead head byte.

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // the only reader checks rx_empty before popping.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd)    rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/uart_rx.sv
// UART receiver, 8N1.
// Confirms the start bit at mid-bit, samples eight data bits LSB first
// and checks the stop bit. A low stop bit gives frame_error instead of rx_done.

`timescale 1ns/1ps
`include "game_link_defines.svh"

module uart_rx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx,
    output game_link_pkg::link_byte_t rx_data,
    output logic                      rx_done,
    output logic                      frame_error
);

    localparam int cnt_w = $clog2(`CLKS_PER_BIT);
    localparam logic [cnt_w-1:0] half_bit = cnt_w'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             rx_meta;
    logic             rx_sync;
    logic             sample_data;

    // two flops on the asynchronous line.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign sample_data = (state == s_data) && (clk_cnt == full_bit);

    always_ff @(posedge clk) begin
        if (sample_data) begin
            rx_data <= {rx_sync, rx_data[7:1]}; // lsb arrives first.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= s_idle;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            rx_done     <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_done     <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                s_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= s_start; // falling edge.
                end
                s_start: begin
                    if (rx_sync) begin
                        state <= s_idle; // line rose again before mid-bit.
                    end else if (clk_cnt == half_bit) begin
                        state   <= s_data;
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                s_data: begin
                    if (clk_cnt == full_bit) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= s_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (clk_cnt == full_bit) begin
                        rx_done     <= rx_sync;
                        frame_error <= !rx_sync;
                        clk_cnt     <= '0;
                        state       <= s_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

//--- hdl/game_link_pkg.sv
// Game link types.
// Card value nibble and the link byte, which is read either as a
// control message or as a card message depending on its low nibble.

package game_link_pkg;

    typedef logic [3:0] card_value_t;

    // control message when the opcode is 0.
    typedef struct packed {
        logic [1:0] spare;
        logic       deal;
        logic       dealer_finished;
        logic [3:0] opcode;
    } ctrl_msg_t;

    // card message for slot codes 1 to 15.
    typedef struct packed {
        card_value_t value;
        logic [3:0]  slot;
    } card_msg_t;

    typedef union packed {
        ctrl_msg_t ctrl;
        card_msg_t card;
    } link_byte_t;

endpackage

//--- hdl/game_link_defines.svh
// Game link receive path parameters.
// Serial bit timing, FIFO depth and card slot count shared by the
// receiver, FIFO, decoder and top level.

`ifndef GAME_LINK_DEFINES_SVH
`define GAME_LINK_DEFINES_SVH

// clock cycles per serial bit at the fixed line rate.
`define CLKS_PER_BIT 16

// FIFO depth is 2**FIFO_AW bytes.
`define FIFO_AW 3

// card slots held by the decoder.
`define NUM_CARDS 9

`endif
